/* logic/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

    // Bus widths
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int LEN_W       = 8;

    // Memory geometry
    localparam int MEM_WORDS   = 256;
    localparam int WORD_BYTES  = 4;
    // Byte offset bits dropped from every address
    localparam int WORD_ADDR_W = ADDR_W - $clog2(WORD_BYTES);

    // AXI burst encodings, RSVD treated as INCR
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10,
        RSVD  = 2'b11
    } burst_e;

    // Only two response codes are produced
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Captured AW or AR request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_e            burst;
    } burst_req_t;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,
        WRITE_DATA,
        WRITE_WAIT,
        WRITE_RESP,
        READ_DATA
    } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if import axi_mem_pkg::*; (
    input logic reset
);

    // Access strobes from the controller
    logic                   en;
    logic                   we;
    // Word address from the address generator
    logic [WORD_ADDR_W-1:0] word_addr;
    // Data path
    logic [DATA_W-1:0]      wdata;
    logic [DATA_W-1:0]      rdata;
    // Out of range flag, registered with the access
    logic                   err;

    modport ctrl (output en, output we, input err);

    modport agen (output word_addr);

    modport mem (
        input  reset,
        input  en,
        input  we,
        input  word_addr,
        input  wdata,
        output rdata,
        output err
    );

endinterface

`default_nettype wire

/* logic/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter import axi_mem_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  logic [LEN_W-1:0] len,
    input  logic             advance,
    output logic             last
);

    // Beats remaining, one wider than len to hold 256
    logic [LEN_W:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            // AXI len field is beats minus one
            count <= {1'b0, len} + 1'b1;
        end else if (advance && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // One beat left
    assign last = (count == (LEN_W + 1)'(1));

endmodule

`default_nettype wire

/* logic/addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_gen import axi_mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic       advance,
    input  burst_req_t req,
    mem_port_if.agen   port
);

    logic [WORD_ADDR_W-1:0] word_q;
    logic [WORD_ADDR_W-1:0] word_next;
    // Window size minus one, in words
    logic [WORD_ADDR_W-1:0] wrap_mask;
    logic                   wrap_ok;

    // WRAP only for 2, 4, 8 or 16 beats
    always_comb begin
        case (req.len)
            8'd1, 8'd3, 8'd7, 8'd15: wrap_ok = 1'b1;
            default:                 wrap_ok = 1'b0;
        endcase
    end

    assign wrap_mask = {{(WORD_ADDR_W - LEN_W){1'b0}}, req.len};

    always_comb begin
        case (req.burst)
            FIXED: begin
                word_next = word_q;
            end
            WRAP: begin
                if (wrap_ok) begin
                    // Keep the window base, wrap the offset inside it
                    word_next = (word_q & ~wrap_mask) | ((word_q + 1'b1) & wrap_mask);
                end else begin
                    word_next = word_q + 1'b1;
                end
            end
            // INCR and reserved code
            default: begin
                word_next = word_q + 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word_q <= '0;
        end else if (load) begin
            // Byte offset bits ignored
            word_q <= req.addr[ADDR_W-1:ADDR_W-WORD_ADDR_W];
        end else if (advance) begin
            word_q <= word_next;
        end
    end

    assign port.word_addr = word_q;

endmodule

`default_nettype wire

/* logic/mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_array import axi_mem_pkg::*; (
    input logic     clk,
    mem_port_if.mem port
);

    logic [DATA_W-1:0]              words [MEM_WORDS];
    logic                           in_range;
    logic [$clog2(MEM_WORDS)-1:0]   idx;

    // Single range check for both write and read
    assign in_range = (port.word_addr < WORD_ADDR_W'(MEM_WORDS));
    assign idx      = port.word_addr[$clog2(MEM_WORDS)-1:0];

    // Storage, out of range writes dropped
    always_ff @(posedge clk) begin
        if (port.en && port.we && in_range) begin
            words[idx] <= port.wdata;
        end
    end

    // Registered read data and range flag
    always_ff @(posedge clk or posedge port.reset) begin
        if (port.reset) begin
            port.rdata <= '0;
            port.err   <= 1'b0;
        end else if (port.en) begin
            port.err <= !in_range;
            // rdata holds across writes and idle cycles
            if (!port.we) begin
                port.rdata <= in_range ? words[idx] : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_ctrl import axi_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // Write address channel
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [LEN_W-1:0]  awlen,
    input  logic [1:0]        awburst,
    input  logic              awvalid,
    output logic              awready,
    // Write data channel, data itself goes straight to the memory
    input  logic              wvalid,
    input  logic              wlast,
    output logic              wready,
    // Write response channel
    output resp_e             bresp,
    output logic              bvalid,
    input  logic              bready,
    // Read address channel
    input  logic [ADDR_W-1:0] araddr,
    input  logic [LEN_W-1:0]  arlen,
    input  logic [1:0]        arburst,
    input  logic              arvalid,
    output logic              arready,
    // Read data channel, data comes from the memory register
    output resp_e             rresp,
    output logic              rlast,
    output logic              rvalid,
    input  logic              rready,
    // Beat counter and address generator
    input  logic              last,
    output logic              load,
    output logic              advance,
    output burst_req_t        req,
    mem_port_if.ctrl          mem
);

    ctrl_state_e state;
    // Read wins the next tie when set
    logic        prio_read;
    burst_req_t  req_q;
    logic        grant_w;
    logic        grant_r;
    logic        w_hs;
    logic        r_hs;
    logic        rd_issue;
    // Reads still to be fetched in this burst
    logic        fetch_pend;
    // A write went to memory last cycle, so err belongs to it
    logic        wr_acc_q;
    logic        err_flag;
    logic        rvalid_q;
    logic        rlast_q;

    // Grant one waiting request in IDLE, none while reset is held
    assign grant_w = !reset && (state == IDLE) && awvalid && (!arvalid || !prio_read);
    assign grant_r = !reset && (state == IDLE) && arvalid && (!awvalid || prio_read);
    assign awready = grant_w;
    assign arready = grant_r;
    assign load    = grant_w || grant_r;

    assign wready = (state == WRITE_DATA);
    assign w_hs   = wvalid && wready;

    // Prefetch while the output slot is empty or being emptied
    assign rd_issue = (state == READ_DATA) && fetch_pend && (!rvalid_q || rready);
    assign r_hs     = rvalid_q && rready;

    assign advance = w_hs || rd_issue;
    assign mem.en  = w_hs || rd_issue;
    assign mem.we  = w_hs;

    // New request on the grant cycle, held copy afterwards
    always_comb begin
        if (grant_w) begin
            req = '{addr: awaddr, len: awlen, burst: burst_e'(awburst)};
        end else if (grant_r) begin
            req = '{addr: araddr, len: arlen, burst: burst_e'(arburst)};
        end else begin
            req = req_q;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req;
        end
    end

    assign bvalid = (state == WRITE_RESP);
    assign bresp  = err_flag ? SLVERR : OKAY;

    // Memory err is registered together with rdata, so it lines up per beat
    assign rvalid = rvalid_q;
    assign rlast  = rlast_q;
    assign rresp  = mem.err ? SLVERR : OKAY;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            prio_read  <= 1'b0;
            fetch_pend <= 1'b0;
            wr_acc_q   <= 1'b0;
            err_flag   <= 1'b0;
            rvalid_q   <= 1'b0;
            rlast_q    <= 1'b0;
        end else begin
            wr_acc_q <= mem.we;

            // Sticky write error, range or WLAST mismatch
            if (load) begin
                err_flag <= 1'b0;
            end else if ((wr_acc_q && mem.err) || (w_hs && (wlast != last))) begin
                err_flag <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (grant_w) begin
                        state     <= WRITE_DATA;
                        prio_read <= 1'b1;
                    end else if (grant_r) begin
                        state      <= READ_DATA;
                        prio_read  <= 1'b0;
                        fetch_pend <= 1'b1;
                    end
                end

                WRITE_DATA: begin
                    if (w_hs && last) begin
                        state <= WRITE_WAIT;
                    end
                end

                // Last beat's range flag arrives here
                WRITE_WAIT: begin
                    state <= WRITE_RESP;
                end

                WRITE_RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end

                READ_DATA: begin
                    if (rd_issue) begin
                        rvalid_q <= 1'b1;
                        rlast_q  <= last;
                        if (last) begin
                            fetch_pend <= 1'b0;
                        end
                    end else if (r_hs) begin
                        rvalid_q <= 1'b0;
                        rlast_q  <= 1'b0;
                    end
                    if (r_hs && rlast_q) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/axi_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top import axi_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // Write address channel
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [LEN_W-1:0]  awlen,
    input  logic [1:0]        awburst,
    input  logic              awvalid,
    output logic              awready,
    // Write data channel
    input  logic [DATA_W-1:0] wdata,
    input  logic              wvalid,
    input  logic              wlast,
    output logic              wready,
    // Write response channel
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    // Read address channel
    input  logic [ADDR_W-1:0] araddr,
    input  logic [LEN_W-1:0]  arlen,
    input  logic [1:0]        arburst,
    input  logic              arvalid,
    output logic              arready,
    // Read data channel
    output logic [DATA_W-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rlast,
    output logic              rvalid,
    input  logic              rready
);

    burst_req_t req;
    logic       load;
    logic       advance;
    logic       last;

    mem_port_if mem_bus (.reset(reset));

    // Data path goes around the controller
    assign mem_bus.wdata = wdata;
    assign rdata         = mem_bus.rdata;

    burst_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .last    (last),
        .load    (load),
        .advance (advance),
        .req     (req),
        .mem     (mem_bus.ctrl)
    );

    beat_counter u_count (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .len     (req.len),
        .advance (advance),
        .last    (last)
    );

    addr_gen u_agen (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .advance (advance),
        .req     (req),
        .port    (mem_bus.agen)
    );

    mem_array u_mem (
        .clk  (clk),
        .port (mem_bus.mem)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for four full cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/axi_mem_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_asserts import axi_mem_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic [1:0]        bresp,
    input logic              bvalid,
    input logic              bready,
    input logic              arvalid,
    input logic              arready,
    input logic [DATA_W-1:0] rdata,
    input logic [1:0]        rresp,
    input logic              rlast,
    input logic              rvalid,
    input logic              rready,
    input logic              last,
    input ctrl_state_e       state
);

    // Count of failed checks
    int   assert_fails = 0;
    // A burst is granted and its response is still owed
    logic busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if ((awvalid && awready) || (arvalid && arready)) begin
            busy <= 1'b1;
        end else if ((bvalid && bready) || (rvalid && rready && rlast)) begin
            busy <= 1'b0;
        end
    end

    // Never two grants in one cycle
    no_dual_grant: assert property (@(posedge clk) !(awready && arready))
    else begin
        $error("AWREADY and ARREADY high in the same cycle");
        assert_fails++;
    end

    // Outputs quiet while reset is high
    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !(awready || wready || arready || bvalid || rvalid))
    else begin
        $error("valid or ready output high during reset");
        assert_fails++;
    end

    // B payload held until BREADY
    b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        $error("BVALID or BRESP changed before the handshake");
        assert_fails++;
    end

    // R payload held until RREADY
    r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
    else begin
        $error("RVALID or R payload changed before the handshake");
        assert_fails++;
    end

    // Response completes before any new grant
    resp_before_grant: assert property (@(posedge clk) disable iff (reset)
        busy |-> !(awready || arready))
    else begin
        $error("new grant while a response was outstanding");
        assert_fails++;
    end

    // Final W beat, one wait cycle, then BVALID
    b_timing: assert property (@(posedge clk) disable iff (reset)
        wvalid && wready && last |=> (state == WRITE_WAIT) ##1 bvalid)
    else begin
        $error("BVALID not two edges after the final W beat");
        assert_fails++;
    end

    // First R beat two edges after AR
    r_timing: assert property (@(posedge clk) disable iff (reset)
        arvalid && arready |=> !rvalid ##1 rvalid)
    else begin
        $error("RVALID not two edges after the AR handshake");
        assert_fails++;
    end

endmodule

bind axi_mem_top axi_mem_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready),
    .last    (last),
    .state   (u_ctrl.state)
);

`default_nettype wire

/* dv/tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem import axi_mem_pkg::*; ();

    logic              clk;
    logic              reset;
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    logic [1:0]        awburst;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wlast;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    logic [1:0]        arburst;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rlast;
    logic              rvalid;
    logic              rready;

    // Reference copy of the memory
    logic [DATA_W-1:0] model [MEM_WORDS];
    int unsigned       beats_issued;
    // Random gaps on W, random BREADY and RREADY
    bit                back_pressure;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    axi_mem_top DUT (.*);

    task automatic fail_run(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic pick_ready();
        if (!back_pressure) begin
            return 1'b1;
        end
        return ($urandom % 2) == 0;
    endfunction

    // Word address of beat i for FIXED, INCR and WRAP
    function automatic int unsigned beat_word(input int unsigned start,
                                              input int unsigned len,
                                              input logic [1:0]  burst,
                                              input int unsigned i);
        int unsigned size;
        int unsigned base;
        size = len + 1;
        base = start - (start % size);
        if (burst == FIXED) begin
            return start;
        end
        // Window of len+1 words aligned to its size, 2 to 16 beats only
        if (burst == WRAP && (size == 2 || size == 4 || size == 8 || size == 16)) begin
            return base + ((start - base + i) % size);
        end
        return start + i;
    endfunction

    // wlast_beat picks the beat that carries WLAST, past len means never
    task automatic write_burst(input int unsigned word, input int unsigned len,
                               input logic [1:0] burst, input int unsigned wlast_beat);
        int unsigned       beat;
        int unsigned       addr;
        logic [1:0]        exp_resp;
        logic [DATA_W-1:0] data;
        logic              stall;
        exp_resp = OKAY;
        beats_issued += len + 1;
        @(negedge clk);
        // Low address bits are don't care
        awaddr  = (word << 2) | ($urandom % 4);
        awlen   = len[7:0];
        awburst = burst;
        awvalid = 1'b1;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        stall   = 1'b0;
        beat    = 0;
        while (beat <= len) begin
            // Beat stays put while it waits for WREADY
            if (!stall) begin
                data   = $urandom;
                wvalid = !back_pressure || (($urandom % 4) != 0);
                wdata  = data;
                wlast  = (beat == wlast_beat);
            end
            #1;
            stall = wvalid && !wready;
            if (wvalid && wready) begin
                addr = beat_word(word, len, burst, beat);
                if (addr < MEM_WORDS) begin
                    model[addr[7:0]] = data;
                end else begin
                    exp_resp = SLVERR;
                end
                // WLAST must match the beat count
                if ((beat == wlast_beat) != (beat == len)) begin
                    exp_resp = SLVERR;
                end
                beat++;
            end
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = pick_ready();
        #1;
        while (!(bvalid && bready)) begin
            @(negedge clk);
            bready = pick_ready();
            #1;
        end
        assert (bresp == exp_resp)
        else fail_run($sformatf("BRESP %0d expected %0d, burst at word %0d", bresp,
                                exp_resp, word));
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_burst(input int unsigned word, input int unsigned len,
                              input logic [1:0] burst);
        int unsigned       beat;
        int unsigned       addr;
        logic [DATA_W-1:0] exp_data;
        logic [1:0]        exp_resp;
        beats_issued += len + 1;
        @(negedge clk);
        araddr  = (word << 2) | ($urandom % 4);
        arlen   = len[7:0];
        arburst = burst;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        beat    = 0;
        while (beat <= len) begin
            rready = pick_ready();
            #1;
            if (rvalid && rready) begin
                addr = beat_word(word, len, burst, beat);
                // Out of range beats read zero with SLVERR
                exp_data = (addr < MEM_WORDS) ? model[addr[7:0]] : '0;
                exp_resp = (addr < MEM_WORDS) ? OKAY : SLVERR;
                assert (rdata == exp_data)
                else fail_run($sformatf("RDATA %h expected %h, beat %0d at word %0d",
                                        rdata, exp_data, beat, addr));
                assert (rresp == exp_resp)
                else fail_run($sformatf("RRESP %0d expected %0d, beat %0d at word %0d",
                                        rresp, exp_resp, beat, addr));
                assert (rlast == (beat == len))
                else fail_run($sformatf("RLAST %0b on beat %0d of %0d", rlast, beat,
                                        len + 1));
                beat++;
            end
            @(negedge clk);
        end
        rready = 1'b0;
    endtask

    // Protocol checks end the run at once
    always @(negedge clk) begin
        if (DUT.u_asserts.assert_fails != 0) begin
            fail_run("a protocol assertion failed");
        end
    end

    // Budget of 40 cycles per issued beat plus slack for reset
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > (beats_issued + 16) * 40) begin
                $display("Watchdog expired after %0d cycles, a handshake never completed",
                         cycles);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin : main
        int unsigned word;
        int unsigned len;
        int unsigned rword;
        int unsigned rlen;
        void'($urandom(32'h94f));
        awaddr        = '0;
        awlen         = '0;
        awburst       = '0;
        // Requests waiting through reset must see no ready
        awvalid       = 1'b1;
        wdata         = '0;
        wvalid        = 1'b0;
        wlast         = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arlen         = '0;
        arburst       = '0;
        arvalid       = 1'b1;
        rready        = 1'b0;
        back_pressure = 1'b0;
        beats_issued  = 0;
        wait (!reset);
        awvalid = 1'b0;
        arvalid = 1'b0;
        @(negedge clk);

        // Fill the whole memory in one burst, then INCR round trips
        write_burst(0, 255, INCR, 255);
        read_burst(0, 255, INCR);
        repeat (6) begin
            len  = $urandom % 64;
            word = $urandom % (MEM_WORDS - len);
            write_burst(word, len, INCR, len);
            read_burst(word, len, INCR);
        end
        // Reserved code runs as INCR
        write_burst(30, 6, RSVD, 6);
        read_burst(30, 6, INCR);

        // WRAP from mid window, read back linearly from the base
        write_burst(42, 3, WRAP, 3);
        read_burst(40, 3, INCR);
        write_burst(101, 7, WRAP, 7);
        read_burst(96, 7, INCR);
        read_burst(101, 7, WRAP);
        // Six beats cannot wrap
        write_burst(20, 5, WRAP, 5);
        read_burst(20, 5, INCR);

        // FIXED keeps the last beat only
        write_burst(200, 5, FIXED, 5);
        read_burst(200, 5, FIXED);

        // Back-pressure stays on from here
        back_pressure = 1'b1;
        repeat (6) begin
            len  = $urandom % 16;
            word = $urandom % (MEM_WORDS - len);
            write_burst(word, len, INCR, len);
            read_burst(word, len, INCR);
        end
        write_burst(150, 3, WRAP, 3);
        read_burst(148, 3, INCR);

        // Beats past word 255
        write_burst(250, 11, INCR, 11);
        read_burst(250, 11, INCR);
        // WLAST early, then never
        write_burst(10, 3, INCR, 1);
        write_burst(14, 3, INCR, 4);
        read_burst(10, 7, INCR);

        // Write and read requested together on disjoint regions
        repeat (4) begin
            word  = 128 + ($urandom % 48);
            len   = $urandom % 16;
            rword = $urandom % 48;
            rlen  = $urandom % 16;
            fork
                write_burst(word, len, INCR, len);
                read_burst(rword, rlen, INCR);
            join
            read_burst(word, len, INCR);
        end

        repeat (4) @(negedge clk);
        if (DUT.u_asserts.assert_fails == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("a protocol assertion failed before the end of the run");
        end
    end

endmodule

`default_nettype wire

/* axi_mem_top.f */
logic/axi_mem_pkg.sv
logic/mem_port_if.sv
logic/beat_counter.sv
logic/addr_gen.sv
logic/mem_array.sv
logic/burst_ctrl.sv
logic/axi_mem_top.sv
dv/tb_clock.sv
dv/axi_mem_asserts.sv
dv/tb_axi_mem.sv

/* Makefile */
# Verilator flow for the AXI burst memory slave
# Override any variable on the command line, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
FILELIST  ?= axi_mem_top.f
TB_TOP    ?= tb_axi_mem
RTL_TOP   ?= axi_mem_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail, grep returns the status
sim: build
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
